//--- files.f
+incdir+include
logic/aesTypesPkg.sv
logic/aesCtrlPkg.sv
logic/roundStepIf.sv
logic/aesSbox.sv
logic/aesKeySchedule.sv
logic/aesRoundDatapath.sv
logic/aesSequencer.sv
logic/aesTop.sv
tests/aes_props.sv
tests/aesTb.sv

//--- include/aesRefModel.svh
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

function automatic logic [7:0] refMul(input logic [7:0] a, input logic [7:0] b);
	logic [7:0] prod;
	logic [7:0] term;
	prod = 8'h00;
	term = a;
	for (int i = 0; i < 8; i++) begin
		if (b[i])
			prod = prod ^ term;
		term = {term[6:0], 1'b0} ^ (term[7] ? 8'h1B : 8'h00);
	end
	return prod;
endfunction

// inverse found by searching all nonzero bytes
function automatic logic [7:0] refSbox(input logic [7:0] x);
	logic [7:0] inv;
	logic [7:0] res;
	inv = 8'h00;
	for (int y = 1; y < 256; y++) begin
		if (refMul(x, 8'(y)) == 8'h01)
			inv = 8'(y);
	end
	for (int i = 0; i < 8; i++)
		res[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
	return res ^ 8'h63;
endfunction

function automatic logic [127:0] aesEncryptRef(input logic [127:0] pt, input logic [127:0] key);
	logic [7:0] s[16];
	logic [7:0] t[16];
	logic [7:0] k[16];
	logic [7:0] rc;
	logic [127:0] res;
	for (int i = 0; i < 16; i++) begin
		s[i] = pt[127-8*i -: 8] ^ key[127-8*i -: 8];
		k[i] = key[127-8*i -: 8];
	end
	rc = 8'h01;
	for (int r = 1; r <= 10; r++) begin
		k[0] = k[0] ^ refSbox(k[13]) ^ rc; // RotWord folded into the byte order
		k[1] = k[1] ^ refSbox(k[14]);
		k[2] = k[2] ^ refSbox(k[15]);
		k[3] = k[3] ^ refSbox(k[12]);
		for (int i = 4; i < 16; i++)
			k[i] = k[i] ^ k[i-4];
		rc = refMul(rc, 8'h02);
		for (int i = 0; i < 16; i++)
			t[(i%4) + 4*(((i/4) + 4 - (i%4)) % 4)] = refSbox(s[i]); // sub then shift
		for (int c = 0; c < 4; c++) begin
			s[4*c] = (r < 10) ? refMul(t[4*c], 8'h02) ^ refMul(t[4*c+1], 8'h03) ^ t[4*c+2]
				^ t[4*c+3] : t[4*c];
			s[4*c+1] = (r < 10) ? t[4*c] ^ refMul(t[4*c+1], 8'h02) ^ refMul(t[4*c+2], 8'h03)
				^ t[4*c+3] : t[4*c+1];
			s[4*c+2] = (r < 10) ? t[4*c] ^ t[4*c+1] ^ refMul(t[4*c+2], 8'h02)
				^ refMul(t[4*c+3], 8'h03) : t[4*c+2];
			s[4*c+3] = (r < 10) ? refMul(t[4*c], 8'h03) ^ t[4*c+1] ^ t[4*c+2]
				^ refMul(t[4*c+3], 8'h02) : t[4*c+3];
		end
		for (int i = 0; i < 16; i++)
			s[i] = s[i] ^ k[i];
	end
	for (int i = 0; i < 16; i++)
		res[127-8*i -: 8] = s[i];
	return res;
endfunction

`endif

//--- tests/aesTb.sv
`include "aes_cfg.svh"

module aesTb;
	import aesTypesPkg::*;

	localparam int clockPeriod = 8;
	localparam int latencyEdges = 1 + 4 * (`AES_ROUNDS - 1) + 3;
	localparam int randomBlocks = 40;
	localparam int backToBack = 4;
	localparam int plannedBlocks = 2 + randomBlocks + backToBack + 3; // busy, aborted, after reset
	localparam int plannedChecks = plannedBlocks - 1; // aborted block never completes

	logic clock;
	logic reset;
	logic start;
	aesBlock plainText;
	aesBlock key;
	aesBlock cipherText;
	logic done;

	aesBlock expQ[$];
	int edgeQ[$];
	int edgeCount = 0;
	int remaining = 0;
	int checkedCount = 0;
	logic prevDone = 1'b0;
	aesBlock expected;
	int sampledAt;
	aesBlock savedPlain;
	aesBlock savedKey;

	`include "aesRefModel.svh"

	aesTop uut (
		.clock(clock),
		.reset(reset),
		.start(start),
		.plainText(plainText),
		.key(key),
		.cipherText(cipherText),
		.done(done)
	);

	initial clock = 1'b0;
	always #(clockPeriod / 2) clock = ~clock;

	task automatic checkValue(input string name, input logic [127:0] actual,
			input logic [127:0] expValue);
		if (actual !== expValue) begin
			$display("[FAIL] %s: got %0h, expected %0h", name, actual, expValue);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	function automatic aesBlock randomBlock();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic startBlock(input aesBlock pt, input aesBlock k);
		@(posedge clock);
		#1;
		plainText = pt;
		key = k;
		start = 1'b1;
		@(posedge clock); // sampling edge
		#1;
		start = 1'b0;
	endtask

	task automatic waitDone();
		@(posedge done);
		#1;
	endtask

	task automatic encryptBlock(input aesBlock pt, input aesBlock k);
		startBlock(pt, k);
		waitDone();
	endtask

	// start counts only when no block is in flight
	always @(posedge clock) begin
		edgeCount++;
		if (reset) begin
			remaining = 0;
			expQ.delete();
			edgeQ.delete();
		end else if (remaining > 0) begin
			remaining--;
		end else if (start) begin
			expQ.push_back(aesEncryptRef(plainText, key));
			edgeQ.push_back(edgeCount);
			remaining = latencyEdges;
		end
	end

	always @(negedge clock) begin
		if (done && !prevDone) begin
			if (expQ.size() == 0) begin
				failRun("done rose with no encryption pending");
			end else begin
				expected = expQ.pop_front();
				sampledAt = edgeQ.pop_front();
				checkValue("cipherText", cipherText, expected);
				checkValue("latency", edgeCount - sampledAt, latencyEdges);
				checkedCount++;
			end
		end
		prevDone = done;
	end

	initial begin
		#(clockPeriod * (60 * plannedBlocks + 100));
		$display("watchdog expired before all encryptions finished");
		$display("Test failed");
		$fatal(1);
	end

	initial begin
		void'($urandom(74));
		reset = 1'b1;
		start = 1'b0;
		plainText = '0;
		key = '0;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
		checkValue("done", done, 0);
		checkValue("cipherText", cipherText, 0);

		// published known answers
		encryptBlock(128'h00112233445566778899aabbccddeeff, 128'h000102030405060708090a0b0c0d0e0f);
		checkValue("cipherText", cipherText, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
		encryptBlock(128'h0, 128'h0);
		checkValue("cipherText", cipherText, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e);

		for (int i = 0; i < randomBlocks; i++)
			encryptBlock(randomBlock(), randomBlock());

		// with start held high each done cycle doubles as the next sampling edge
		@(posedge clock);
		#1;
		plainText = randomBlock();
		key = randomBlock();
		start = 1'b1;
		for (int i = 0; i < backToBack; i++) begin
			waitDone();
			if (i < backToBack - 1) begin
				plainText = randomBlock();
				key = randomBlock();
			end else begin
				start = 1'b0;
			end
		end

		savedPlain = randomBlock();
		savedKey = randomBlock();
		startBlock(savedPlain, savedKey);
		for (int i = 0; i < 3; i++) begin
			repeat (6) @(posedge clock);
			#1;
			plainText = randomBlock(); // must not disturb the block in flight
			key = randomBlock();
			start = 1'b1;
			@(posedge clock);
			#1;
			start = 1'b0;
		end
		waitDone();
		checkValue("cipherText", cipherText, aesEncryptRef(savedPlain, savedKey));

		// reset in the middle of a block
		startBlock(randomBlock(), randomBlock());
		repeat (15) @(posedge clock);
		#1 reset = 1'b1;
		#1;
		checkValue("done", done, 0);
		checkValue("cipherText", cipherText, 0);
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;
		encryptBlock(randomBlock(), randomBlock());

		repeat (2) @(negedge clock);
		if (expQ.size() != 0 || checkedCount != plannedChecks || uut.uProps.assertFails != 0) begin
			$display("end of run with %0d of %0d results checked and %0d assertion failures",
				checkedCount, plannedChecks, uut.uProps.assertFails);
			$display("Test failed");
			$fatal(1);
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

//--- tests/aes_props.sv
`include "aes_cfg.svh"

module aesProps (
	input logic clock,
	input logic reset,
	input logic start,
	input aesTypesPkg::aesBlock cipherText,
	input logic done,
	input aesCtrlPkg::seqState state
);
	import aesCtrlPkg::*;

	localparam int latency = 4 * `AES_ROUNDS; // 1 + 4*(rounds-1) + 3

	int assertFails = 0;
	logic sampling;

	assign sampling = start && (state == stIdle || state == stDone);

	doneFalls: assert property (@(posedge clock) disable iff (reset)
		sampling |=> !done)
		else begin
			assertFails++;
			$error("done still high on the edge after a sampled start");
		end

	// ciphertext must hold for as long as done does
	cipherStable: assert property (@(posedge clock) disable iff (reset)
		done ##1 done |-> $stable(cipherText))
		else begin
			assertFails++;
			$error("cipherText changed while done was high");
		end

	doneLatency: assert property (@(posedge clock) disable iff (reset)
		sampling |=> (!done) [*latency] ##1 done)
		else begin
			assertFails++;
			$error("done did not rise exactly %0d edges after start", latency);
		end

	noUnknown: assert property (@(posedge clock) disable iff (reset)
		!$isunknown({done, cipherText}))
		else begin
			assertFails++;
			$error("unknown value on done or cipherText");
		end

endmodule

bind aesTop aesProps uProps (
	.clock(clock),
	.reset(reset),
	.start(start),
	.cipherText(cipherText),
	.done(done),
	.state(uSequencer.state)
);

//--- logic/aesTop.sv
module aesTop (
	input logic clock,
	input logic reset,
	input logic start,
	input aesTypesPkg::aesBlock plainText,
	input aesTypesPkg::aesBlock key,
	output aesTypesPkg::aesBlock cipherText,
	output logic done
);
	import aesTypesPkg::*;

	aesBlock roundKey;

	roundStepIf step ();

	aesSequencer uSequencer (
		.clock(clock),
		.reset(reset),
		.start(start),
		.step(step.sequencer),
		.done(done)
	);

	aesKeySchedule uKeys (
		.clock(clock),
		.reset(reset),
		.step(step.keys),
		.key(key),
		.roundKey(roundKey)
	);

	aesRoundDatapath uDatapath (
		.clock(clock),
		.reset(reset),
		.step(step.datapath),
		.plainText(plainText),
		.roundKey(roundKey),
		.cipherText(cipherText)
	);

endmodule

//--- logic/aesSequencer.sv
`include "aes_cfg.svh"

module aesSequencer (
	input logic clock,
	input logic reset,
	input logic start,
	roundStepIf.sequencer step,
	output logic done
);
	import aesCtrlPkg::*;
	import aesTypesPkg::*;

	seqState state;
	seqState nextState;
	roundIndex round;
	logic lastRound;

	assign lastRound = (round == roundIndex'(`AES_ROUNDS));

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= stIdle;
			round <= '0;
		end else begin
			state <= nextState;
			if (step.load)
				round <= '0; // every block starts counting from zero
			else if (step.addFirst || step.addRound)
				round <= round + 1'b1;
		end
	end

	always_comb begin
		nextState = state;
		step.load = 1'b0;
		step.addFirst = 1'b0;
		step.subStep = 1'b0;
		step.shiftStep = 1'b0;
		step.mixStep = 1'b0;
		step.addRound = 1'b0;
		step.finish = 1'b0;
		case (state)
			stIdle, stDone: begin
				if (start) begin
					step.load = 1'b1;
					nextState = stAddKey;
				end
			end
			stAddKey: begin
				step.addFirst = 1'b1;
				nextState = stSub;
			end
			stSub: begin
				step.subStep = 1'b1;
				nextState = stShift;
			end
			stShift: begin
				step.shiftStep = 1'b1;
				nextState = lastRound ? stAddRound : stMix; // final round has no MixColumns
			end
			stMix: begin
				step.mixStep = 1'b1;
				nextState = stAddRound;
			end
			stAddRound: begin
				if (lastRound) begin
					step.finish = 1'b1;
					nextState = stDone;
				end else begin
					step.addRound = 1'b1;
					nextState = stSub;
				end
			end
			default: nextState = stIdle;
		endcase
	end

	assign done = (state == stDone);

endmodule

//--- logic/aesRoundDatapath.sv
`include "aes_cfg.svh"

module aesRoundDatapath (
	input logic clock,
	input logic reset,
	roundStepIf.datapath step,
	input aesTypesPkg::aesBlock plainText,
	input aesTypesPkg::aesBlock roundKey,
	output aesTypesPkg::aesBlock cipherText
);
	import aesTypesPkg::*;

	aesBlock plainReg;
	aesBlock stateReg;  // result of the last AddRoundKey
	aesBlock subReg;
	aesBlock shiftReg;
	aesBlock mixReg;
	aesBlock outReg;
	aesBlock subBytes;

	// one computed substitution per byte for SubBytes
	for (genvar i = 0; i < 16; i++) begin : genSubBytes
		aesSbox uSbox (
			.inByte(stateReg[`AES_BYTE_BITS*i +: `AES_BYTE_BITS]),
			.outByte(subBytes[`AES_BYTE_BITS*i +: `AES_BYTE_BITS])
		);
	end

	always_ff @(posedge clock) begin
		if (step.load)
			plainReg <= plainText;
	end

	always_ff @(posedge clock) begin
		if (step.addFirst)
			stateReg <= plainReg ^ roundKey;
		else if (step.addRound)
			stateReg <= mixReg ^ roundKey;
	end

	always_ff @(posedge clock) begin
		if (step.subStep)
			subReg <= subBytes;
	end

	always_ff @(posedge clock) begin
		if (step.shiftStep)
			shiftReg <= shiftRows(subReg);
	end

	always_ff @(posedge clock) begin
		if (step.mixStep)
			mixReg <= mixColumns(shiftReg);
	end

	// last round skips MixColumns and lands here
	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			outReg <= '0;
		else if (step.finish)
			outReg <= shiftReg ^ roundKey;
	end

	assign cipherText = outReg;

endmodule

//--- logic/aesKeySchedule.sv
`include "aes_cfg.svh"

module aesKeySchedule (
	input logic clock,
	input logic reset,
	roundStepIf.keys step,
	input aesTypesPkg::aesBlock key,
	output aesTypesPkg::aesBlock roundKey
);
	import aesTypesPkg::*;

	aesBlock keyReg;
	aesBlock nextKey;
	aesByte rcon;
	aesWord w0, w1, w2, w3;
	aesWord rotWord;
	aesWord subWord;
	aesWord g;

	assign {w0, w1, w2, w3} = keyReg;
	assign rotWord = {w3[23:0], w3[31:24]};

	// SubWord on the rotated last column
	for (genvar i = 0; i < 4; i++) begin : genSubWord
		aesSbox uSbox (
			.inByte(rotWord[`AES_BYTE_BITS*i +: `AES_BYTE_BITS]),
			.outByte(subWord[`AES_BYTE_BITS*i +: `AES_BYTE_BITS])
		);
	end

	assign g = subWord ^ {rcon, 24'h000000};

	// each new word chains on the one before it
	assign nextKey[127:96] = w0 ^ g;
	assign nextKey[95:64] = w1 ^ nextKey[127:96];
	assign nextKey[63:32] = w2 ^ nextKey[95:64];
	assign nextKey[31:0] = w3 ^ nextKey[63:32];

	always_ff @(posedge clock) begin
		if (step.load)
			keyReg <= key;
		else if (step.addFirst || step.addRound)
			keyReg <= nextKey; // step to the key of the next round
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			rcon <= `AES_RCON_FIRST;
		else if (step.load)
			rcon <= `AES_RCON_FIRST;
		else if (step.addFirst || step.addRound)
			rcon <= xtime(rcon);
	end

	assign roundKey = keyReg;

endmodule

//--- logic/aesSbox.sv
`include "aes_cfg.svh"

module aesSbox (
	input aesTypesPkg::aesByte inByte,
	output aesTypesPkg::aesByte outByte
);
	import aesTypesPkg::*;

	aesByte square;
	aesByte inverse;

	// x^254 is the field inverse by square and multiply over exponent bits 1..7
	always_comb begin
		square = inByte;
		inverse = 8'h01;
		for (int i = 1; i < `AES_BYTE_BITS; i++) begin
			square = gfMul(square, square); // x^(2^i)
			inverse = gfMul(inverse, square);
		end
	end

	// zero has no inverse but x^254 of zero is zero, which gives 63 after the affine step

	// each bit of the affine map xors with the four bits above it cyclically
	assign outByte = inverse
		^ {inverse[6:0], inverse[7]}
		^ {inverse[5:0], inverse[7:6]}
		^ {inverse[4:0], inverse[7:5]}
		^ {inverse[3:0], inverse[7:4]}
		^ `AES_AFFINE_C;

endmodule

//--- logic/roundStepIf.sv
interface roundStepIf;

	logic load;      // capture plaintext and key
	logic addFirst;  // initial AddRoundKey
	logic subStep;
	logic shiftStep;
	logic mixStep;
	logic addRound;  // AddRoundKey after MixColumns
	logic finish;    // last AddRoundKey into output register

	modport sequencer(
		output load, addFirst, subStep, shiftStep, mixStep, addRound, finish
	);

	modport datapath(
		input load, addFirst, subStep, shiftStep, mixStep, addRound, finish
	);

	modport keys(input load, addFirst, addRound);

endinterface

//--- logic/aesCtrlPkg.sv
package aesCtrlPkg;

	// one state per registered stage, idle and done wait for start
	typedef enum logic [2:0] {
		stIdle,
		stAddKey,
		stSub,
		stShift,
		stMix,
		stAddRound,
		stDone
	} seqState;

endpackage

//--- logic/aesTypesPkg.sv
`include "aes_cfg.svh"

package aesTypesPkg;

	// byte 0 sits in the top bits, columns of four bytes follow each other
	typedef logic [`AES_BLOCK_BITS-1:0] aesBlock;
	typedef logic [4*`AES_BYTE_BITS-1:0] aesWord;
	typedef logic [`AES_BYTE_BITS-1:0] aesByte;
	typedef logic [3:0] roundIndex;

	function automatic aesByte xtime(input aesByte b);
		return {b[6:0], 1'b0} ^ (b[7] ? `AES_GF_POLY : 8'h00);
	endfunction

	function automatic aesByte gfMul(input aesByte a, input aesByte b);
		aesByte prod;
		aesByte term;
		prod = '0;
		term = a;
		for (int i = 0; i < `AES_BYTE_BITS; i++) begin
			if (b[i])
				prod = prod ^ term;
			term = xtime(term);
		end
		return prod;
	endfunction

	function automatic aesBlock shiftRows(input aesBlock b);
		aesBlock s;
		s = '0;
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++)
				s[127 - 8*(r + 4*c) -: 8] = b[127 - 8*(r + 4*((c + r) % 4)) -: 8]; // row r rotates left by r
		end
		return s;
	endfunction

	function automatic aesBlock mixColumns(input aesBlock b);
		aesBlock m;
		aesWord col;
		m = '0;
		for (int c = 0; c < 4; c++) begin
			col = b[127 - 32*c -: 32];
			m[127 - 32*c -: 32] = {
				xtime(col[31:24]) ^ xtime(col[23:16]) ^ col[23:16] ^ col[15:8] ^ col[7:0],
				col[31:24] ^ xtime(col[23:16]) ^ xtime(col[15:8]) ^ col[15:8] ^ col[7:0],
				col[31:24] ^ col[23:16] ^ xtime(col[15:8]) ^ xtime(col[7:0]) ^ col[7:0],
				xtime(col[31:24]) ^ col[31:24] ^ col[23:16] ^ col[15:8] ^ xtime(col[7:0])};
		end
		return m;
	endfunction

endpackage

//--- include/aes_cfg.svh
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

`define AES_ROUNDS 10
`define AES_BLOCK_BITS 128
`define AES_BYTE_BITS 8

// low byte of the field reduction x^8 + x^4 + x^3 + x + 1
`define AES_GF_POLY 8'h1B
`define AES_AFFINE_C 8'h63
`define AES_RCON_FIRST 8'h01

`endif
